// File: lsu_fwd.f
+incdir+.
lsu_req_pkg.sv
lsu_wbuf_pkg.sv
lsu_fwd_stage.sv
lsu_wbuf_entry.sv
lsu_fwd_merge.sv
lsu_fwd_top.sv
lsu_fwd_asserts.sv
lsu_fwd_checker.sv
tb_lsu_fwd.sv

// File: tb_lsu_fwd.sv
//********************
// testbench for store forwarding and the write buffer
// applies the stimulus table one row per cycle, checker and assertions judge
//********************
`timescale 1ns/1ps

module tb_lsu_fwd;

  localparam logic [1:0] OP_IDLE  = 2'd0;
  localparam logic [1:0] OP_STORE = 2'd1;
  localparam logic [1:0] OP_LOAD  = 2'd2;
  localparam logic [1:0] OP_DRAIN = 2'd3;
  localparam lsu_req_pkg::acc_size_e SZ_B = lsu_req_pkg::SZ_BYTE;
  localparam lsu_req_pkg::acc_size_e SZ_H = lsu_req_pkg::SZ_HALF;
  localparam lsu_req_pkg::acc_size_e SZ_W = lsu_req_pkg::SZ_WORD;
  localparam int N_ROWS     = 23;
  localparam int MAX_CYCLES = N_ROWS + 20;

  typedef struct packed {
    logic [1:0]              op;
    lsu_req_pkg::acc_size_e  size;
    logic [31:0]             addr;      // head address on drain rows
    logic [31:0]             data;
    logic                    commit;
    logic [31:0]             exp_data;  // load data or head data
    logic                    exp_hit;
    logic                    exp_full;
    logic                    exp_empty;
  } row_t;

  logic                      clk;
  logic                      rst_n;
  lsu_req_pkg::lsu_pkt_t     req_m;
  logic                      commit_r;
  logic                      wbuf_drain;
  logic [31:0]               fwd_data_m;
  logic                      full_hit_m;
  lsu_wbuf_pkg::lane_word_t  wbuf_head;
  logic                      wbuf_head_valid;
  logic                      wbuf_full;
  logic                      wbuf_empty;

  row_t    tbl [N_ROWS];
  row_t    cur_row;
  logic    row_vld;
  logic    commit_pend;  // commit goes with the store one cycle later
  int      n_fill;
  int      cyc_cnt;
  int      err_cnt;
  int      chk_cnt;
  int      total_err;
  integer  seed;

  task automatic add_row(input logic [1:0] op, input lsu_req_pkg::acc_size_e size,
                         input logic [31:0] addr, input logic [31:0] data,
                         input logic commit, input logic [31:0] exp_data,
                         input logic exp_hit, input logic exp_full, input logic exp_empty);
    tbl[n_fill] = '{op, size, addr, data, commit, exp_data, exp_hit, exp_full, exp_empty};
    n_fill++;
  endtask

  task automatic fill_table();
    // forward from r, then from the buffer, uncommitted store dropped
    add_row(OP_STORE, SZ_W, 32'h0000_0100, 32'h1122_3344, 1'b1, 32'h0, 1'b0, 1'b0, 1'b1);
    add_row(OP_LOAD,  SZ_W, 32'h0000_0100, 32'h0, 1'b0, 32'h1122_3344, 1'b1, 1'b0, 1'b1);
    add_row(OP_IDLE,  SZ_W, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD,  SZ_W, 32'h0000_0100, 32'h0, 1'b0, 32'h1122_3344, 1'b1, 1'b0, 1'b0);
    add_row(OP_STORE, SZ_W, 32'h0000_0200, 32'hAABB_CCDD, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row(OP_IDLE,  SZ_W, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD,  SZ_W, 32'h0000_0200, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0);
    // byte and half merge into one entry, partial then full word load
    add_row(OP_STORE, SZ_B, 32'h0000_0302, 32'h0000_00EE, 1'b1, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row(OP_STORE, SZ_H, 32'h0000_0300, 32'h0000_BBAA, 1'b1, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD,  SZ_W, 32'h0000_0300, 32'h0, 1'b0, 32'h00EE_BBAA, 1'b0, 1'b0, 1'b0);
    add_row(OP_STORE, SZ_B, 32'h0000_0303, 32'h0000_00FF, 1'b1, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row(OP_IDLE,  SZ_W, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD,  SZ_W, 32'h0000_0300, 32'h0, 1'b0, 32'hFFEE_BBAA, 1'b1, 1'b0, 1'b0);
    // misaligned half load across two words, buffer fills up
    add_row(OP_STORE, SZ_B, 32'h0000_0403, 32'h0000_0077, 1'b1, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row(OP_STORE, SZ_B, 32'h0000_0404, 32'h0000_0088, 1'b1, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row(OP_LOAD,  SZ_H, 32'h0000_0403, 32'h0, 1'b0, 32'h0000_8877, 1'b1, 1'b1, 1'b0);
    add_row(OP_LOAD,  SZ_H, 32'h0000_0403, 32'h0, 1'b0, 32'h0000_8877, 1'b1, 1'b1, 1'b0);
    // drains in allocation order
    add_row(OP_DRAIN, SZ_W, 32'h0000_0100, 32'h0, 1'b0, 32'h1122_3344, 1'b0, 1'b1, 1'b0);
    add_row(OP_DRAIN, SZ_W, 32'h0000_0300, 32'h0, 1'b0, 32'hFFEE_BBAA, 1'b0, 1'b1, 1'b0);
    add_row(OP_DRAIN, SZ_W, 32'h0000_0400, 32'h0, 1'b0, 32'h7700_0000, 1'b0, 1'b0, 1'b0);
    add_row(OP_DRAIN, SZ_W, 32'h0000_0404, 32'h0, 1'b0, 32'h0000_0088, 1'b0, 1'b0, 1'b0);
    add_row(OP_IDLE,  SZ_W, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b1);
    add_row(OP_IDLE,  SZ_W, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b1);
  endtask

  // called on a rising edge
  task automatic drive_row(input row_t r);
    lsu_req_pkg::lsu_pkt_t pkt;
    pkt = '{valid: (r.op == OP_STORE) || (r.op == OP_LOAD), load: r.op == OP_LOAD,
            store: r.op == OP_STORE, size: r.size, addr: r.addr, data: r.data};
    if (r.op == OP_IDLE) begin
      pkt.addr = $random(seed);  // filler, request stays invalid
      pkt.data = $random(seed);
    end
    req_m       <= pkt;
    wbuf_drain  <= (r.op == OP_DRAIN);
    commit_r    <= commit_pend;
    commit_pend <= r.commit & (r.op == OP_STORE);
    cur_row     <= r;
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  lsu_fwd_top i_lsu_fwd_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_m           (req_m),
    .commit_r        (commit_r),
    .wbuf_drain      (wbuf_drain),
    .fwd_data_m      (fwd_data_m),
    .full_hit_m      (full_hit_m),
    .wbuf_head       (wbuf_head),
    .wbuf_head_valid (wbuf_head_valid),
    .wbuf_full       (wbuf_full),
    .wbuf_empty      (wbuf_empty)
  );

  lsu_fwd_checker i_lsu_fwd_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .row_vld         (row_vld),
    .is_load         (cur_row.op == OP_LOAD),
    .is_drain        (cur_row.op == OP_DRAIN),
    .exp_addr        (cur_row.addr),
    .exp_data        (cur_row.exp_data),
    .exp_hit         (cur_row.exp_hit),
    .exp_full        (cur_row.exp_full),
    .exp_empty       (cur_row.exp_empty),
    .fwd_data_m      (fwd_data_m),
    .full_hit_m      (full_hit_m),
    .wbuf_head       (wbuf_head),
    .wbuf_head_valid (wbuf_head_valid),
    .wbuf_full       (wbuf_full),
    .wbuf_empty      (wbuf_empty),
    .err_cnt         (err_cnt),
    .chk_cnt         (chk_cnt)
  );

  //********************
  // timeout
  //********************
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_cnt <= 0;
    end else if (cyc_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the stimulus table did not finish", cyc_cnt);
      $display("Checks failed");
      $finish;
    end else begin
      cyc_cnt <= cyc_cnt + 1;
    end
  end

  //********************
  // stimulus and closing
  //********************
  initial begin
    seed        = 32'hffec_f0db;
    n_fill      = 0;
    rst_n       = 1'b0;
    req_m       = '0;
    commit_r    = 1'b0;
    wbuf_drain  = 1'b0;
    commit_pend = 1'b0;
    cur_row     = '0;
    row_vld     = 1'b0;
    fill_table();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < N_ROWS; i++) begin
      @(posedge clk);
      drive_row(tbl[i]);
      row_vld <= 1'b1;
    end
    @(posedge clk);
    drive_row('0);
    row_vld <= 1'b0;
    repeat (2) @(posedge clk);
    total_err = err_cnt + i_lsu_fwd_top.i_lsu_fwd_asserts.fail_cnt;
    if (n_fill != N_ROWS) begin
      $display("stimulus table holds %0d rows instead of %0d", n_fill, N_ROWS);
      total_err++;
    end
    $display("rows %0d, checks %0d, compare errors %0d, assertion failures %0d",
             N_ROWS, chk_cnt, err_cnt, i_lsu_fwd_top.i_lsu_fwd_asserts.fail_cnt);
    if (total_err == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: lsu_fwd_checker.sv
//********************
// compares DUT outputs with the expected columns of the current table row
//********************
`timescale 1ns/1ps

module lsu_fwd_checker (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      row_vld,
  input  logic                      is_load,
  input  logic                      is_drain,
  input  logic [31:0]               exp_addr,
  input  logic [31:0]               exp_data,
  input  logic                      exp_hit,
  input  logic                      exp_full,
  input  logic                      exp_empty,
  input  logic [31:0]               fwd_data_m,
  input  logic                      full_hit_m,
  input  lsu_wbuf_pkg::lane_word_t  wbuf_head,
  input  logic                      wbuf_head_valid,
  input  logic                      wbuf_full,
  input  logic                      wbuf_empty,
  output int                        err_cnt,
  output int                        chk_cnt
);

  logic [31:0] head_data;

  // lanes never written hold no defined data
  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  assign head_data = wbuf_head.data & lane_mask(wbuf_head.byteen);

  initial begin
    err_cnt = 0;
    chk_cnt = 0;
  end

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst_n && row_vld) begin
      chk_cnt++;
      if (wbuf_full !== exp_full || wbuf_empty !== exp_empty) begin
        err_cnt++;
        $display("ERR %0t: full %b empty %b, expected full %b empty %b",
                 $time, wbuf_full, wbuf_empty, exp_full, exp_empty);
      end
      // full hit stays low on every row without a valid load
      if (full_hit_m !== exp_hit) begin
        err_cnt++;
        $display("ERR %0t: full hit %b, expected %b", $time, full_hit_m, exp_hit);
      end
      if (is_load && fwd_data_m !== exp_data) begin
        err_cnt++;
        $display("ERR %0t: load %h gave data %h, expected %h",
                 $time, exp_addr, fwd_data_m, exp_data);
      end
      if (is_drain && (wbuf_head_valid !== 1'b1 || wbuf_head.waddr !== exp_addr[31:2] ||
                       head_data !== exp_data)) begin
        err_cnt++;
        $display("ERR %0t: head valid %b word %h data %h, expected word %h data %h",
                 $time, wbuf_head_valid, wbuf_head.waddr, head_data,
                 exp_addr[31:2], exp_data);
      end
    end
  end

endmodule

// File: lsu_fwd_asserts.sv
//********************
// write buffer usage rules, bound into the forwarding top
//********************
`timescale 1ns/1ps

module lsu_fwd_asserts (
  input  logic                   clk,
  input  logic                   rst_n,
  input  lsu_req_pkg::lsu_pkt_t  req_m,
  input  logic                   wbuf_drain,
  input  logic                   wbuf_full,
  input  logic                   wbuf_empty,
  input  logic                   wbuf_head_valid
);

  int fail_cnt = 0;  // read by the testbench at the end

  // source must hold stores back while full
  a_no_store_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    (req_m.valid && req_m.store) |-> !wbuf_full)
    else begin
      fail_cnt++;
      $error("store request while the write buffer is full");
    end

  a_head_valid_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    wbuf_head_valid == !wbuf_empty)
    else begin
      fail_cnt++;
      $error("head valid does not match the empty flag");
    end

  a_no_drain_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
    wbuf_drain |-> !wbuf_empty)
    else begin
      fail_cnt++;
      $error("drain pulse while the write buffer is empty");
    end

endmodule

bind lsu_fwd_top lsu_fwd_asserts i_lsu_fwd_asserts (.*);

// File: lsu_fwd_top.sv
//********************
// store forwarding and coalescing write buffer top
//********************
`timescale 1ns/1ps
`include "lsu_fwd_defs.svh"

module lsu_fwd_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  lsu_req_pkg::lsu_pkt_t     req_m,
  input  logic                      commit_r,
  input  logic                      wbuf_drain,
  output logic [31:0]               fwd_data_m,
  output logic                      full_hit_m,
  output lsu_wbuf_pkg::lane_word_t  wbuf_head,
  output logic                      wbuf_head_valid,
  output logic                      wbuf_full,
  output logic                      wbuf_empty
);

  lsu_wbuf_pkg::lane_word_t   st_lo_r;
  lsu_wbuf_pkg::lane_word_t   st_hi_r;
  lsu_wbuf_pkg::lane_word_t   ld_lo_m;
  lsu_wbuf_pkg::lane_word_t   ld_hi_m;
  logic                       st_lo_vld_r;
  logic                       st_hi_vld_r;
  logic                       ld_vld_m;
  logic [`LSU_WBUF_DEPTH-1:0] wr_en_lo;
  logic [`LSU_WBUF_DEPTH-1:0] wr_en_hi;
  logic [`LSU_WBUF_DEPTH-1:0] entry_match_lo;
  logic [`LSU_WBUF_DEPTH-1:0] entry_match_hi;
  logic [`LSU_WBUF_DEPTH-1:0] entry_valid;
  logic [`LSU_WBUF_PTR_W-1:0] head_ptr;
  lsu_wbuf_pkg::lane_word_t   entry_contents [`LSU_WBUF_DEPTH];
  lsu_wbuf_pkg::wbuf_hit_t    entry_hit [`LSU_WBUF_DEPTH];

  lsu_fwd_stage i_lsu_fwd_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_m          (req_m),
    .commit_r       (commit_r),
    .wbuf_drain     (wbuf_drain),
    .entry_match_lo (entry_match_lo),
    .entry_match_hi (entry_match_hi),
    .entry_valid    (entry_valid),
    .st_lo_r        (st_lo_r),
    .st_hi_r        (st_hi_r),
    .st_lo_vld_r    (st_lo_vld_r),
    .st_hi_vld_r    (st_hi_vld_r),
    .ld_lo_m        (ld_lo_m),
    .ld_hi_m        (ld_hi_m),
    .ld_vld_m       (ld_vld_m),
    .wr_en_lo       (wr_en_lo),
    .wr_en_hi       (wr_en_hi),
    .head_ptr       (head_ptr),
    .wbuf_full      (wbuf_full),
    .wbuf_empty     (wbuf_empty)
  );

  for (genvar i = 0; i < `LSU_WBUF_DEPTH; i++) begin : g_entry
    lsu_wbuf_entry i_lsu_wbuf_entry (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_en_lo (wr_en_lo[i]),
      .wr_en_hi (wr_en_hi[i]),
      .st_lo_r  (st_lo_r),
      .st_hi_r  (st_hi_r),
      .drain_me (wbuf_drain & (head_ptr == `LSU_WBUF_PTR_W'(i))),  // head slot only
      .ld_lo_m  (ld_lo_m),
      .ld_hi_m  (ld_hi_m),
      .match_lo (entry_match_lo[i]),
      .match_hi (entry_match_hi[i]),
      .valid    (entry_valid[i]),
      .contents (entry_contents[i]),
      .hit      (entry_hit[i])
    );
  end

  lsu_fwd_merge i_lsu_fwd_merge (
    .st_lo_r         (st_lo_r),
    .st_hi_r         (st_hi_r),
    .st_lo_vld_r     (st_lo_vld_r),
    .st_hi_vld_r     (st_hi_vld_r),
    .ld_lo_m         (ld_lo_m),
    .ld_hi_m         (ld_hi_m),
    .ld_vld_m        (ld_vld_m),
    .hits            (entry_hit),
    .contents        (entry_contents),
    .entry_valid     (entry_valid),
    .head_ptr        (head_ptr),
    .fwd_data_m      (fwd_data_m),
    .full_hit_m      (full_hit_m),
    .wbuf_head       (wbuf_head),
    .wbuf_head_valid (wbuf_head_valid)
  );

endmodule

// File: lsu_fwd_merge.sv
//********************
// byte-wise forward select, r stage over buffer, plus head entry output
//********************
`timescale 1ns/1ps
`include "lsu_fwd_defs.svh"

module lsu_fwd_merge (
  input  lsu_wbuf_pkg::lane_word_t  st_lo_r,
  input  lsu_wbuf_pkg::lane_word_t  st_hi_r,
  input  logic                      st_lo_vld_r,
  input  logic                      st_hi_vld_r,
  input  lsu_wbuf_pkg::lane_word_t  ld_lo_m,
  input  lsu_wbuf_pkg::lane_word_t  ld_hi_m,
  input  logic                      ld_vld_m,
  input  lsu_wbuf_pkg::wbuf_hit_t   hits [`LSU_WBUF_DEPTH],
  input  lsu_wbuf_pkg::lane_word_t  contents [`LSU_WBUF_DEPTH],
  input  logic [`LSU_WBUF_DEPTH-1:0] entry_valid,
  input  logic [`LSU_WBUF_PTR_W-1:0] head_ptr,
  output logic [31:0]               fwd_data_m,
  output logic                      full_hit_m,
  output lsu_wbuf_pkg::lane_word_t  wbuf_head,
  output logic                      wbuf_head_valid
);

  // rhit_<store half>_<load half>
  logic [3:0]  rhit_lo_lo;
  logic [3:0]  rhit_hi_lo;
  logic [3:0]  rhit_lo_hi;
  logic [3:0]  rhit_hi_hi;
  logic [3:0]  rhit_lo;
  logic [3:0]  rhit_hi;
  logic [3:0]  bhit_lo;
  logic [3:0]  bhit_hi;
  logic [31:0] rdata_lo;
  logic [31:0] rdata_hi;
  logic [31:0] bdata_lo;
  logic [31:0] bdata_hi;
  logic [31:0] fdata_lo;
  logic [31:0] fdata_hi;
  logic [63:0] fdata_ext;
  logic [1:0]  ld_off;

  //********************
  // r stage hits
  //********************
  assign rhit_lo_lo = {4{st_lo_vld_r & (st_lo_r.waddr == ld_lo_m.waddr)}} &
                      st_lo_r.byteen & ld_lo_m.byteen;
  assign rhit_hi_lo = {4{st_hi_vld_r & (st_hi_r.waddr == ld_lo_m.waddr)}} &
                      st_hi_r.byteen & ld_lo_m.byteen;
  assign rhit_lo_hi = {4{st_lo_vld_r & (st_lo_r.waddr == ld_hi_m.waddr)}} &
                      st_lo_r.byteen & ld_hi_m.byteen;
  assign rhit_hi_hi = {4{st_hi_vld_r & (st_hi_r.waddr == ld_hi_m.waddr)}} &
                      st_hi_r.byteen & ld_hi_m.byteen;

  assign rhit_lo = rhit_lo_lo | rhit_hi_lo;
  assign rhit_hi = rhit_lo_hi | rhit_hi_hi;

  //********************
  // buffer hits
  //********************
  // at most one entry holds a given word, so OR is enough
  always_comb begin
    bhit_lo  = '0;
    bhit_hi  = '0;
    bdata_lo = '0;
    bdata_hi = '0;
    for (int e = 0; e < `LSU_WBUF_DEPTH; e++) begin
      bhit_lo |= hits[e].hit_lo;
      bhit_hi |= hits[e].hit_hi;
      for (int b = 0; b < 4; b++) begin
        bdata_lo[8*b +: 8] |= {8{hits[e].hit_lo[b]}} & hits[e].data[8*b +: 8];
        bdata_hi[8*b +: 8] |= {8{hits[e].hit_hi[b]}} & hits[e].data[8*b +: 8];
      end
    end
  end

  for (genvar b = 0; b < 4; b++) begin : g_byte
    assign rdata_lo[8*b +: 8] = ({8{rhit_lo_lo[b]}} & st_lo_r.data[8*b +: 8]) |
                                ({8{rhit_hi_lo[b]}} & st_hi_r.data[8*b +: 8]);
    assign rdata_hi[8*b +: 8] = ({8{rhit_lo_hi[b]}} & st_lo_r.data[8*b +: 8]) |
                                ({8{rhit_hi_hi[b]}} & st_hi_r.data[8*b +: 8]);

    // younger r stage byte wins
    assign fdata_lo[8*b +: 8] = rhit_lo[b] ? rdata_lo[8*b +: 8] : bdata_lo[8*b +: 8];
    assign fdata_hi[8*b +: 8] = rhit_hi[b] ? rdata_hi[8*b +: 8] : bdata_hi[8*b +: 8];
  end

  // byte offset is the lowest requested lo lane
  always_comb begin
    ld_off = 2'd0;
    for (int b = 3; b >= 0; b--) begin
      if (ld_lo_m.byteen[b]) begin
        ld_off = 2'(b);
      end
    end
  end

  assign fdata_ext  = {fdata_hi, fdata_lo} >> {ld_off, 3'b000};
  assign fwd_data_m = fdata_ext[31:0];

  assign full_hit_m = ld_vld_m &
                      (&(rhit_lo | bhit_lo | ~ld_lo_m.byteen)) &
                      (&(rhit_hi | bhit_hi | ~ld_hi_m.byteen));

  assign wbuf_head       = contents[head_ptr];  // oldest entry
  assign wbuf_head_valid = entry_valid[head_ptr];

endmodule

// File: lsu_wbuf_entry.sv
//********************
// one write buffer entry, merges stores to its word and answers loads
//********************
`timescale 1ns/1ps
`include "lsu_fwd_defs.svh"

module lsu_wbuf_entry (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wr_en_lo,
  input  logic                      wr_en_hi,
  input  lsu_wbuf_pkg::lane_word_t  st_lo_r,
  input  lsu_wbuf_pkg::lane_word_t  st_hi_r,
  input  logic                      drain_me,
  input  lsu_wbuf_pkg::lane_word_t  ld_lo_m,
  input  lsu_wbuf_pkg::lane_word_t  ld_hi_m,
  output logic                      match_lo,
  output logic                      match_hi,
  output logic                      valid,
  output lsu_wbuf_pkg::lane_word_t  contents,
  output lsu_wbuf_pkg::wbuf_hit_t   hit
);

  lsu_wbuf_pkg::lane_word_t wr_word;
  logic                     wr_en;
  logic                     keep;
  logic                     ld_lo_hit;
  logic                     ld_hi_hit;

  assign wr_en   = wr_en_lo | wr_en_hi;
  assign wr_word = wr_en_hi ? st_hi_r : st_lo_r;
  assign keep    = valid & ~drain_me;  // old bytes survive only if not leaving

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (wr_en) begin
      valid <= 1'b1;  // refill wins over drain
    end else if (drain_me) begin
      valid <= 1'b0;
    end
  end

  // only enabled lanes are overwritten
  always_ff @(posedge clk) begin
    if (wr_en) begin
      contents.waddr  <= wr_word.waddr;
      contents.byteen <= keep ? (contents.byteen | wr_word.byteen) : wr_word.byteen;
      for (int b = 0; b < 4; b++) begin
        if (wr_word.byteen[b]) begin
          contents.data[8*b +: 8] <= wr_word.data[8*b +: 8];
        end
      end
    end
  end

  // same word as the store in r, used for coalescing
  assign match_lo = valid & (contents.waddr == st_lo_r.waddr);
  assign match_hi = valid & (contents.waddr == st_hi_r.waddr);

  assign ld_lo_hit = valid & (contents.waddr == ld_lo_m.waddr);
  assign ld_hi_hit = valid & (contents.waddr == ld_hi_m.waddr);

  assign hit.hit_lo = {4{ld_lo_hit}} & contents.byteen & ld_lo_m.byteen;
  assign hit.hit_hi = {4{ld_hi_hit}} & contents.byteen & ld_hi_m.byteen;
  assign hit.data   = contents.data;

endmodule

// File: lsu_fwd_stage.sv
//********************
// m to r store pipe, lane expansion and write buffer allocation
// feeds the entries and the forward merge
//********************
`timescale 1ns/1ps
`include "lsu_fwd_defs.svh"

module lsu_fwd_stage (
  input  logic                        clk,
  input  logic                        rst_n,
  input  lsu_req_pkg::lsu_pkt_t       req_m,
  input  logic                        commit_r,
  input  logic                        wbuf_drain,
  input  logic [`LSU_WBUF_DEPTH-1:0]  entry_match_lo,
  input  logic [`LSU_WBUF_DEPTH-1:0]  entry_match_hi,
  input  logic [`LSU_WBUF_DEPTH-1:0]  entry_valid,
  output lsu_wbuf_pkg::lane_word_t    st_lo_r,
  output lsu_wbuf_pkg::lane_word_t    st_hi_r,
  output logic                        st_lo_vld_r,
  output logic                        st_hi_vld_r,
  output lsu_wbuf_pkg::lane_word_t    ld_lo_m,
  output lsu_wbuf_pkg::lane_word_t    ld_hi_m,
  output logic                        ld_vld_m,
  output logic [`LSU_WBUF_DEPTH-1:0]  wr_en_lo,
  output logic [`LSU_WBUF_DEPTH-1:0]  wr_en_hi,
  output logic [`LSU_WBUF_PTR_W-1:0]  head_ptr,
  output logic                        wbuf_full,
  output logic                        wbuf_empty
);

  logic [3:0]                  byteen_m;
  logic [1:0]                  size_off;    // size in bytes minus one
  logic [7:0]                  byteen_ext_m;
  logic [63:0]                 data_ext_m;
  logic [`LSU_ADDR_W-1:0]      end_addr_m;
  logic                        st_m;

  logic [`LSU_WBUF_PTR_W-1:0]  tail_ptr;
  logic [`LSU_WBUF_PTR_W-1:0]  tail_nxt;
  logic [`LSU_WBUF_PTR_W:0]    used_cnt;
  logic [`LSU_WBUF_DEPTH-1:0]  drain_oh;
  logic [`LSU_WBUF_DEPTH-1:0]  tail_oh;
  logic [`LSU_WBUF_DEPTH-1:0]  tail_nxt_oh;
  logic [`LSU_WBUF_DEPTH-1:0]  hit_lo;
  logic [`LSU_WBUF_DEPTH-1:0]  hit_hi;
  logic                        wr_lo;
  logic                        wr_hi;
  logic                        alloc_lo;
  logic                        alloc_hi;
  logic                        drain_do;
  logic [1:0]                  alloc_cnt;

  //********************
  // m stage lane expansion
  //********************
  always_comb begin
    byteen_m = 4'b1111;
    size_off = 2'd3;
    case (req_m.size)
      lsu_req_pkg::SZ_BYTE: begin
        byteen_m = 4'b0001;
        size_off = 2'd0;
      end
      lsu_req_pkg::SZ_HALF: begin
        byteen_m = 4'b0011;
        size_off = 2'd1;
      end
      default: begin
        byteen_m = 4'b1111;
        size_off = 2'd3;
      end
    endcase
  end

  assign end_addr_m   = req_m.addr + `LSU_ADDR_W'(size_off);
  assign byteen_ext_m = {4'b0000, byteen_m} << req_m.addr[1:0];
  assign data_ext_m   = {32'b0, req_m.data} << {req_m.addr[1:0], 3'b000};
  assign st_m         = req_m.valid & req_m.store;

  // load halves only carry lanes and word address
  assign ld_lo_m  = '{byteen: byteen_ext_m[3:0], data: '0, waddr: req_m.addr[`LSU_ADDR_W-1:2]};
  assign ld_hi_m  = '{byteen: byteen_ext_m[7:4], data: '0, waddr: end_addr_m[`LSU_ADDR_W-1:2]};
  assign ld_vld_m = req_m.valid & req_m.load;

  //********************
  // r stage store
  //********************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st_lo_vld_r <= 1'b0;
      st_hi_vld_r <= 1'b0;
    end else begin
      st_lo_vld_r <= st_m;
      st_hi_vld_r <= st_m & (|byteen_ext_m[7:4]);  // misaligned only
    end
  end

  always_ff @(posedge clk) begin
    if (st_m) begin
      st_lo_r <= '{byteen: byteen_ext_m[3:0], data: data_ext_m[31:0],
                   waddr: req_m.addr[`LSU_ADDR_W-1:2]};
      st_hi_r <= '{byteen: byteen_ext_m[7:4], data: data_ext_m[63:32],
                   waddr: end_addr_m[`LSU_ADDR_W-1:2]};
    end
  end

  //********************
  // buffer allocation
  //********************
  assign drain_do = wbuf_drain & entry_valid[head_ptr];
  assign drain_oh = drain_do ? (`LSU_WBUF_DEPTH'(1) << head_ptr) : '0;

  // an entry leaving this cycle cannot take a merge
  assign hit_lo = entry_match_lo & ~drain_oh;
  assign hit_hi = entry_match_hi & ~drain_oh;

  assign wr_lo    = st_lo_vld_r & commit_r;
  assign wr_hi    = st_hi_vld_r & commit_r;
  assign alloc_lo = wr_lo & ~(|hit_lo);
  assign alloc_hi = wr_hi & ~(|hit_hi);

  assign tail_nxt    = tail_ptr + 1'b1;
  assign tail_oh     = `LSU_WBUF_DEPTH'(1) << tail_ptr;
  assign tail_nxt_oh = `LSU_WBUF_DEPTH'(1) << tail_nxt;
  assign alloc_cnt   = {1'b0, alloc_lo} + {1'b0, alloc_hi};

  assign wr_en_lo = !wr_lo ? '0 : (alloc_lo ? tail_oh : hit_lo);

  // hi goes behind lo when both take new slots
  assign wr_en_hi = !wr_hi    ? '0     :
                    !alloc_hi ? hit_hi :
                    alloc_lo  ? tail_nxt_oh : tail_oh;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      used_cnt <= '0;
    end else begin
      head_ptr <= head_ptr + drain_do;
      tail_ptr <= tail_ptr + `LSU_WBUF_PTR_W'(alloc_cnt);
      used_cnt <= used_cnt + (`LSU_WBUF_PTR_W+1)'(alloc_cnt)
                           - (`LSU_WBUF_PTR_W+1)'(drain_do);
    end
  end

  // full leaves room for one misaligned store
  assign wbuf_full  = used_cnt > (`LSU_WBUF_PTR_W+1)'(`LSU_WBUF_DEPTH - 2);
  assign wbuf_empty = (used_cnt == '0);

endmodule

// File: lsu_wbuf_pkg.sv
//********************
// write buffer types shared by the stage, the entries and the merge
//********************
`include "lsu_fwd_defs.svh"

package lsu_wbuf_pkg;

  // one word with its byte lanes and word address
  typedef struct packed {
    logic [`LSU_WORD_BYTES-1:0]   byteen;
    logic [8*`LSU_WORD_BYTES-1:0] data;
    logic [`LSU_ADDR_W-3:0]       waddr;  // addr without byte offset
  } lane_word_t;

  // answer of one entry to the load in m
  typedef struct packed {
    logic [`LSU_WORD_BYTES-1:0]   hit_lo;  // bytes found for the load's lo word
    logic [`LSU_WORD_BYTES-1:0]   hit_hi;  // bytes found for the load's hi word
    logic [8*`LSU_WORD_BYTES-1:0] data;
  } wbuf_hit_t;

endpackage

// File: lsu_req_pkg.sv
//********************
// pipeline request types for the load/store unit
//********************
`include "lsu_fwd_defs.svh"

package lsu_req_pkg;

  // access size carried with each request
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } acc_size_e;

  // request presented at the m stage
  typedef struct packed {
    logic                         valid;
    logic                         load;
    logic                         store;
    acc_size_e                    size;
    logic [`LSU_ADDR_W-1:0]       addr;
    logic [8*`LSU_WORD_BYTES-1:0] data;  // store data, lane 0 aligned
  } lsu_pkt_t;

endpackage

// File: lsu_fwd_defs.svh
//********************
// sizing macros for the load/store forwarding path and write buffer
// include wherever a width or buffer depth is needed
//********************
`ifndef LSU_FWD_DEFS_SVH
`define LSU_FWD_DEFS_SVH

// address bus width
`define LSU_ADDR_W 32

// bytes in one bus word, low address bits select the lane
`define LSU_WORD_BYTES 4

// write buffer entries, 2, 4 or 8
`define LSU_WBUF_DEPTH 4

// head and tail pointer width, log2 of the depth
`define LSU_WBUF_PTR_W 2

`endif
